// File: src/adcfifo_defs.svh
`ifndef ADCFIFO_DEFS_SVH
`define ADCFIFO_DEFS_SVH

// register map
`define REG_FIFO_STAT                8'h10
`define REG_FIFO_STATE               8'h11
`define REG_FIFO_FIRST_ERROR         8'h12
`define REG_STREAM_SEGMENT_THRESHOLD 8'h13
`define REG_ADC_LOW_RES              8'h14
`define REG_FIFO_UNDERFLOW_COUNT     8'h15
`define REG_FIFO_NO_UNDERFLOW_ERROR  8'h16
`define REG_CAPTURE_DONE             8'h17
`define REG_CAPTURE_ARM              8'h18
`define REG_FAST_FIFO_READ_MODE      8'h19
`define REG_ADCREAD_ADDR             8'h03

// field widths
`define ADC_BITS       10
`define THRESHOLD_BITS 17
`define BYTECNT_BITS   7

// sample FIFO
`define ADCFIFO_DEPTH  32

// capture length after reset, in samples
`define THRESHOLD_RESET 17'd65536

`endif

// File: src/adcfifo_pkg.sv
`include "adcfifo_defs.svh"

package adcfifo_pkg;

  typedef struct packed {
    logic [7:0]               address;
    logic [`BYTECNT_BITS-1:0] bytecnt;
    logic [7:0]               datai;
    logic                     read;
    logic                     write;
  } reg_bus_t;

  typedef enum logic [2:0] {
    IDLE    = 3'd0,
    ARMED   = 3'd1,
    CAPTURE = 3'd2,
    DONE    = 3'd3
  } capture_state_e;

  // one FIFO word, either a single full sample or two low-res bytes
  typedef union packed {
    struct packed {
      logic [15-`ADC_BITS:0] pad;
      logic [`ADC_BITS-1:0]  sample;
    } full;
    struct packed {
      logic [7:0] hi; // later sample
      logic [7:0] lo; // earlier sample
    } pair;
  } sample_word_u;

  typedef struct packed {
    logic       empty;
    logic       overflow;
    logic       underflow;
    logic [7:0] reserved;
  } fifo_err_t;

endpackage

// File: src/reg_adcfifo.sv
`include "adcfifo_defs.svh"
`timescale 1ns/100ps

module reg_adcfifo
  import adcfifo_pkg::*;
(
  input  logic                       clk_usb,
  input  logic                       reset,
  input  reg_bus_t                   bus,
  input  capture_state_e             state,
  input  fifo_err_t                  fifo_err,
  input  fifo_err_t                  fifo_first_err,
  input  capture_state_e             first_err_state,
  input  sample_word_u               fifo_head,
  input  logic [7:0]                 underflow_count,
  input  logic                       capture_done,
  output logic [7:0]                 reg_datao,
  output logic                       fifo_rd_en,
  output logic                       low_res,
  output logic                       low_res_lsb,
  output logic                       fast_fifo_read_mode,
  output logic [`THRESHOLD_BITS-1:0] stream_segment_threshold,
  output logic                       clear_fifo_errors,
  output logic                       no_underflow_errors,
  output logic                       arm
);

  logic        read_r;         // read level, one cycle late
  logic        pop_cond;
  logic        fifo_rd_en_reg;
  logic [15:0] stat_word;
  logic [23:0] first_err_word;
  logic [23:0] threshold_word;

  // byte idx of a little-endian word, zero past its last byte
  function automatic logic [7:0] pick_byte(
    input logic [31:0]              word,
    input int unsigned              nbytes,
    input logic [`BYTECNT_BITS-1:0] idx
  );
    logic [7:0] result;
    result = 8'h00;
    if (idx < nbytes) begin
      result = word[idx[1:0]*8 +: 8];
    end
    return result;
  endfunction

  assign stat_word      = {5'b0, fifo_err};
  assign first_err_word = {5'b0, first_err_state, 5'b0, fifo_first_err};
  assign threshold_word = {{(24-`THRESHOLD_BITS){1'b0}}, stream_segment_threshold};

  always_comb begin
    reg_datao = 8'h00;
    if (bus.read) begin
      case (bus.address)
        `REG_FIFO_STAT:                reg_datao = pick_byte({16'b0, stat_word}, 2, bus.bytecnt);
        `REG_FIFO_STATE:               reg_datao = {5'b0, state};
        `REG_FIFO_FIRST_ERROR:         reg_datao = pick_byte({8'b0, first_err_word}, 3,
                                                             bus.bytecnt);
        `REG_STREAM_SEGMENT_THRESHOLD: reg_datao = pick_byte({8'b0, threshold_word}, 3,
                                                             bus.bytecnt);
        `REG_ADC_LOW_RES:              reg_datao = {6'b0, low_res_lsb, low_res};
        `REG_FIFO_UNDERFLOW_COUNT:     reg_datao = underflow_count;
        `REG_FIFO_NO_UNDERFLOW_ERROR:  reg_datao = {7'b0, no_underflow_errors};
        `REG_CAPTURE_DONE:             reg_datao = {7'b0, capture_done};
        `REG_FAST_FIFO_READ_MODE:      reg_datao = {7'b0, fast_fifo_read_mode};
        `REG_ADCREAD_ADDR:             reg_datao = bus.bytecnt[0] ? fifo_head.pair.hi
                                                                  : fifo_head.pair.lo;
        default:                       reg_datao = 8'h00;
      endcase
    end
  end

  // high byte of a sample word pops the FIFO
  assign pop_cond = bus.read && !read_r && (bus.address == `REG_ADCREAD_ADDR) &&
                    bus.bytecnt[0];

  // fast mode pops in the first read cycle
  assign fifo_rd_en = fast_fifo_read_mode ? pop_cond : fifo_rd_en_reg;

  always_ff @(posedge clk_usb) begin
    if (reset) begin
      read_r         <= 1'b0;
      fifo_rd_en_reg <= 1'b0;
    end else begin
      read_r         <= bus.read;
      fifo_rd_en_reg <= pop_cond;
    end
  end

  always_ff @(posedge clk_usb) begin
    if (reset) begin
      low_res                  <= 1'b0;
      low_res_lsb              <= 1'b0;
      clear_fifo_errors        <= 1'b0;
      no_underflow_errors      <= 1'b0;
      stream_segment_threshold <= `THRESHOLD_RESET;
      arm                      <= 1'b0;
    end else begin
      arm <= 1'b0;
      if (bus.write) begin
        case (bus.address)
          `REG_ADC_LOW_RES:             {low_res_lsb, low_res} <= bus.datai[1:0];
          `REG_FIFO_STAT:               clear_fifo_errors <= bus.datai[0];
          `REG_FIFO_NO_UNDERFLOW_ERROR: no_underflow_errors <= bus.datai[0];
          `REG_CAPTURE_ARM:             arm <= bus.datai[0];
          `REG_STREAM_SEGMENT_THRESHOLD: begin
            case (bus.bytecnt)
              7'd0:    stream_segment_threshold[7:0] <= bus.datai;
              7'd1:    stream_segment_threshold[15:8] <= bus.datai;
              7'd2:    stream_segment_threshold[16] <= bus.datai[0];
              default: ;
            endcase
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_usb) begin
    if (reset) begin
      fast_fifo_read_mode <= 1'b0;
    end else if (bus.write) begin
      if (bus.address == `REG_FAST_FIFO_READ_MODE) begin
        fast_fifo_read_mode <= bus.datai[0];
      end else begin
        fast_fifo_read_mode <= 1'b0; // any other write ends fast mode
      end
    end
  end

endmodule

// File: src/adcfifo_capture_fsm.sv
`timescale 1ns/100ps

module adcfifo_capture_fsm
  import adcfifo_pkg::*;
(
  input  logic           clk_usb,
  input  logic           reset,
  input  logic           arm,
  input  logic           trigger,
  input  logic           count_done,
  output capture_state_e state,
  output logic           capturing,
  output logic           capture_done
);

  capture_state_e state_next;

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (arm) begin
          state_next = ARMED;
        end
      end
      ARMED: begin
        if (trigger) begin
          state_next = CAPTURE; // first trigger cycle starts capture
        end
      end
      CAPTURE: begin
        if (count_done) begin
          state_next = DONE;
        end
      end
      DONE: begin
        if (arm) begin
          state_next = ARMED; // rearm for the next capture
        end
      end
      default: begin
        state_next = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_usb) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  // no more samples once the last one was counted
  assign capturing    = (state == CAPTURE) && !count_done;
  assign capture_done = (state == DONE);

endmodule

// File: src/adcfifo_sample_counter.sv
`include "adcfifo_defs.svh"
`timescale 1ns/100ps

module adcfifo_sample_counter (
  input  logic                       clk_usb,
  input  logic                       reset,
  input  logic                       arm,
  input  logic                       capturing,
  input  logic                       adc_valid,
  input  logic [`THRESHOLD_BITS-1:0] stream_segment_threshold,
  input  logic                       underflow_event,
  input  logic                       no_underflow_errors,
  input  logic                       clear_fifo_errors,
  output logic                       count_done,
  output logic [7:0]                 underflow_count,
  output logic                       flush_partial
);

  logic [`THRESHOLD_BITS-1:0] sample_count;
  logic [`THRESHOLD_BITS-1:0] count_next;
  logic                       mask_r; // previous no_underflow_errors

  assign count_next = sample_count + 1'b1;

  always_ff @(posedge clk_usb) begin
    if (reset) begin
      sample_count  <= '0;
      count_done    <= 1'b0;
      flush_partial <= 1'b0;
    end else begin
      count_done    <= 1'b0;
      flush_partial <= 1'b0;
      if (arm) begin
        sample_count <= '0;
      end else if (capturing && adc_valid) begin
        sample_count <= count_next;
        if (count_next >= stream_segment_threshold) begin
          count_done    <= 1'b1;
          flush_partial <= count_next[0]; // odd count leaves a half word
        end
      end
    end
  end

  // underflow count restarts when masking is switched on
  always_ff @(posedge clk_usb) begin
    if (reset) begin
      underflow_count <= 8'h00;
      mask_r          <= 1'b0;
    end else begin
      mask_r <= no_underflow_errors;
      if (clear_fifo_errors || (no_underflow_errors && !mask_r)) begin
        underflow_count <= 8'h00;
      end else if (underflow_event && (underflow_count != 8'hff)) begin
        underflow_count <= underflow_count + 8'h01; // saturates at 255
      end
    end
  end

endmodule

// File: src/adcfifo_sample_fifo.sv
`include "adcfifo_defs.svh"
`timescale 1ns/100ps

module adcfifo_sample_fifo
  import adcfifo_pkg::*;
(
  input  logic                 clk_usb,
  input  logic                 reset,
  input  logic                 arm,
  input  logic                 capturing,
  input  logic                 adc_valid,
  input  logic [`ADC_BITS-1:0] adc_sample,
  input  logic                 low_res,
  input  logic                 low_res_lsb,
  input  logic                 flush_partial,
  input  logic                 fifo_rd_en,
  input  logic                 clear_fifo_errors,
  input  logic                 no_underflow_errors,
  input  capture_state_e       state,
  output sample_word_u         fifo_head,
  output fifo_err_t            fifo_err,
  output fifo_err_t            fifo_first_err,
  output capture_state_e       first_err_state,
  output logic                 underflow_event
);

  localparam int AW = $clog2(`ADCFIFO_DEPTH);
  localparam logic [AW:0] DEPTH_CNT = `ADCFIFO_DEPTH;

  sample_word_u mem [`ADCFIFO_DEPTH];
  sample_word_u wr_word;
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   fill;
  logic          empty;
  logic          full;
  logic          sample_strobe;
  logic          wr_req;
  logic          wr_en;
  logic          rd_en;
  logic [7:0]    lr_byte;
  logic [7:0]    pending_byte; // earlier sample of a low-res pair
  logic          half_pending;
  logic          set_ovf;
  logic          set_udf;
  logic          ovf_err;
  logic          udf_err;
  fifo_err_t     err_next;

  assign sample_strobe = capturing && adc_valid;
  assign lr_byte = low_res_lsb ? adc_sample[7:0] : adc_sample[`ADC_BITS-1:2];

  always_comb begin
    wr_word = '0;
    wr_req  = 1'b0;
    if (sample_strobe) begin
      if (!low_res) begin
        wr_word.full.sample = adc_sample;
        wr_req              = 1'b1;
      end else if (half_pending) begin
        wr_word.pair.lo = pending_byte;
        wr_word.pair.hi = lr_byte;
        wr_req          = 1'b1;
      end
    end else if (flush_partial && half_pending) begin
      wr_word.pair.lo = pending_byte; // high byte stays zero
      wr_req          = 1'b1;
    end
  end

  always_ff @(posedge clk_usb) begin
    if (reset) begin
      half_pending <= 1'b0;
    end else if (arm || flush_partial) begin
      half_pending <= 1'b0;
    end else if (sample_strobe && low_res) begin
      half_pending <= !half_pending;
    end
  end

  always_ff @(posedge clk_usb) begin
    if (sample_strobe && low_res && !half_pending) begin
      pending_byte <= lr_byte;
    end
  end

  assign empty           = (fill == '0);
  assign full            = (fill == DEPTH_CNT);
  assign wr_en           = wr_req && !full;     // dropped when full
  assign rd_en           = fifo_rd_en && !empty;
  assign underflow_event = fifo_rd_en && empty;
  assign set_ovf         = wr_req && full;
  assign set_udf         = underflow_event && !no_underflow_errors;

  always_ff @(posedge clk_usb) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_word;
    end
  end

  assign fifo_head = mem[rd_ptr]; // first word falls through

  always_ff @(posedge clk_usb) begin
    if (reset || arm) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      wr_ptr <= wr_ptr + AW'(wr_en);
      rd_ptr <= rd_ptr + AW'(rd_en);
      case ({wr_en, rd_en})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: ;
      endcase
    end
  end

  assign err_next.empty     = empty;
  assign err_next.overflow  = ovf_err || set_ovf;
  assign err_next.underflow = udf_err || set_udf;
  assign err_next.reserved  = 8'h00;

  assign fifo_err.empty     = empty;
  assign fifo_err.overflow  = ovf_err;
  assign fifo_err.underflow = udf_err;
  assign fifo_err.reserved  = 8'h00;

  always_ff @(posedge clk_usb) begin
    if (reset || clear_fifo_errors) begin
      ovf_err         <= 1'b0;
      udf_err         <= 1'b0;
      fifo_first_err  <= '0;
      first_err_state <= IDLE;
    end else begin
      ovf_err <= err_next.overflow;
      udf_err <= err_next.underflow;
      if (!(ovf_err || udf_err) && (set_ovf || set_udf)) begin
        fifo_first_err  <= err_next; // first error since last clear
        first_err_state <= state;
      end
    end
  end

endmodule

// File: src/adcfifo_top.sv
`include "adcfifo_defs.svh"
`timescale 1ns/100ps

module adcfifo_top
  import adcfifo_pkg::*;
(
  input  logic                 clk_usb,
  input  logic                 reset,
  input  reg_bus_t             bus,
  input  logic [`ADC_BITS-1:0] adc_sample,
  input  logic                 adc_valid,
  input  logic                 trigger,
  output logic [7:0]           reg_datao,
  output logic                 capture_done
);

  capture_state_e             state;
  capture_state_e             first_err_state;
  fifo_err_t                  fifo_err;
  fifo_err_t                  fifo_first_err;
  sample_word_u               fifo_head;
  logic [7:0]                 underflow_count;
  logic [`THRESHOLD_BITS-1:0] stream_segment_threshold;
  logic                       fifo_rd_en;
  logic                       low_res;
  logic                       low_res_lsb;
  logic                       fast_fifo_read_mode;
  logic                       clear_fifo_errors;
  logic                       no_underflow_errors;
  logic                       arm;
  logic                       capturing;
  logic                       count_done;
  logic                       flush_partial;
  logic                       underflow_event;

  reg_adcfifo u_reg (
    .clk_usb                  (clk_usb),
    .reset                    (reset),
    .bus                      (bus),
    .state                    (state),
    .fifo_err                 (fifo_err),
    .fifo_first_err           (fifo_first_err),
    .first_err_state          (first_err_state),
    .fifo_head                (fifo_head),
    .underflow_count          (underflow_count),
    .capture_done             (capture_done),
    .reg_datao                (reg_datao),
    .fifo_rd_en               (fifo_rd_en),
    .low_res                  (low_res),
    .low_res_lsb              (low_res_lsb),
    .fast_fifo_read_mode      (fast_fifo_read_mode),
    .stream_segment_threshold (stream_segment_threshold),
    .clear_fifo_errors        (clear_fifo_errors),
    .no_underflow_errors      (no_underflow_errors),
    .arm                      (arm)
  );

  adcfifo_capture_fsm u_fsm (
    .clk_usb      (clk_usb),
    .reset        (reset),
    .arm          (arm),
    .trigger      (trigger),
    .count_done   (count_done),
    .state        (state),
    .capturing    (capturing),
    .capture_done (capture_done)
  );

  adcfifo_sample_counter u_counter (
    .clk_usb                  (clk_usb),
    .reset                    (reset),
    .arm                      (arm),
    .capturing                (capturing),
    .adc_valid                (adc_valid),
    .stream_segment_threshold (stream_segment_threshold),
    .underflow_event          (underflow_event),
    .no_underflow_errors      (no_underflow_errors),
    .clear_fifo_errors        (clear_fifo_errors),
    .count_done               (count_done),
    .underflow_count          (underflow_count),
    .flush_partial            (flush_partial)
  );

  adcfifo_sample_fifo u_fifo (
    .clk_usb             (clk_usb),
    .reset               (reset),
    .arm                 (arm),
    .capturing           (capturing),
    .adc_valid           (adc_valid),
    .adc_sample          (adc_sample),
    .low_res             (low_res),
    .low_res_lsb         (low_res_lsb),
    .flush_partial       (flush_partial),
    .fifo_rd_en          (fifo_rd_en),
    .clear_fifo_errors   (clear_fifo_errors),
    .no_underflow_errors (no_underflow_errors),
    .state               (state),
    .fifo_head           (fifo_head),
    .fifo_err            (fifo_err),
    .fifo_first_err      (fifo_first_err),
    .first_err_state     (first_err_state),
    .underflow_event     (underflow_event)
  );

endmodule

// File: testbench/tb_adcfifo.sv
`include "adcfifo_defs.svh"
`timescale 1ns/100ps

module tb_adcfifo
  import adcfifo_pkg::*;
();

  logic                 clk_usb = 1'b0;
  logic                 reset;
  reg_bus_t             bus;
  logic [`ADC_BITS-1:0] adc_sample;
  logic                 adc_valid;
  logic                 trigger;
  logic [7:0]           reg_datao;
  logic                 capture_done;

  logic [31:0]  rng_state = 32'h9b76_56a5;
  sample_word_u exp_q[$]; // words the FIFO should hold
  logic         exp_ovf;

  adcfifo_top uut (
    .clk_usb      (clk_usb),
    .reset        (reset),
    .bus          (bus),
    .adc_sample   (adc_sample),
    .adc_valid    (adc_valid),
    .trigger      (trigger),
    .reg_datao    (reg_datao),
    .capture_done (capture_done)
  );

  always #20 clk_usb = ~clk_usb;

  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic fifo_err_t make_err(input logic empty, input logic ovf, input logic udf);
    fifo_err_t e;
    e = '0;
    e.empty     = empty;
    e.overflow  = ovf;
    e.underflow = udf;
    return e;
  endfunction

  // low-res byte kept from one sample
  function automatic logic [7:0] low_res_byte(input logic [`ADC_BITS-1:0] s, input logic lsb);
    return lsb ? s[7:0] : s[9:2];
  endfunction

  task automatic report_failure(input string line);
    $display("%s", line);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("FAIL t=%0t %s: got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_word(input string name, input sample_word_u got, input sample_word_u exp);
    if (got !== exp) begin
      report_failure($sformatf("FAIL t=%0t %s: got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_err(input string name, input fifo_err_t got, input fifo_err_t exp);
    if (got !== exp) begin
      report_failure($sformatf("FAIL t=%0t %s: got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_state(input string name, input capture_state_e got,
                             input capture_state_e exp);
    if (got !== exp) begin
      report_failure($sformatf("FAIL t=%0t %s: got %s expected %s", $time, name,
                               got.name(), exp.name()));
    end
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [`BYTECNT_BITS-1:0] cnt,
                           input logic [7:0] data);
    @(posedge clk_usb);
    bus.address <= addr;
    bus.bytecnt <= cnt;
    bus.datai   <= data;
    bus.read    <= 1'b0;
    bus.write   <= 1'b1;
    @(posedge clk_usb);
    bus.write   <= 1'b0; // write lands on this edge
  endtask

  task automatic read_reg(input logic [7:0] addr, input logic [`BYTECNT_BITS-1:0] cnt,
                          output logic [7:0] data);
    @(posedge clk_usb);
    bus.address <= addr;
    bus.bytecnt <= cnt;
    bus.datai   <= 8'h00;
    bus.read    <= 1'b1;
    bus.write   <= 1'b0;
    @(negedge clk_usb);
    data = reg_datao; // read mux is combinational
    @(posedge clk_usb);
    bus.read    <= 1'b0;
  endtask

  task automatic read_err(input logic [7:0] addr, output fifo_err_t e);
    logic [7:0] b0;
    logic [7:0] b1;
    read_reg(addr, 0, b0);
    read_reg(addr, 1, b1);
    e = fifo_err_t'({b1[2:0], b0});
  endtask

  task automatic read_state(input logic [7:0] addr, input logic [`BYTECNT_BITS-1:0] cnt,
                            output capture_state_e s);
    logic [7:0] b;
    read_reg(addr, cnt, b);
    s = capture_state_e'(b[2:0]);
  endtask

  // odd byte of the pair pops the FIFO
  task automatic read_word(output sample_word_u w);
    logic [7:0] lo;
    logic [7:0] hi;
    read_reg(`REG_ADCREAD_ADDR, 0, lo);
    read_reg(`REG_ADCREAD_ADDR, 1, hi);
    w = sample_word_u'({hi, lo});
  endtask

  task automatic push_word(input sample_word_u w);
    if (exp_q.size() < `ADCFIFO_DEPTH) begin
      exp_q.push_back(w);
    end else begin
      exp_ovf = 1'b1; // FIFO drops it
    end
  endtask

  // starts on the edge that takes the last sample
  task automatic wait_capture_done();
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk_usb);
      cycles++;
    end while (!capture_done && cycles < 200);
    if (!capture_done) begin
      report_failure("capture_done did not rise within 200 cycles after the last sample");
    end
    check_byte("capture_done delay in edges", cycles[7:0], 8'd2); // two edges after strobe
  endtask

  task automatic run_capture(input logic lr, input logic lsb, input int unsigned n);
    logic [`THRESHOLD_BITS-1:0] thr;
    logic [`ADC_BITS-1:0]       s;
    logic [7:0]                 pend;
    logic                       half;
    logic [7:0]                 b;
    int unsigned                gap;
    sample_word_u               w;
    capture_state_e             st;
    fifo_err_t                  e;
    thr     = n;
    half    = 1'b0;
    pend    = 8'h00;
    exp_ovf = 1'b0;
    exp_q.delete();
    write_reg(`REG_ADC_LOW_RES, 0, {6'b0, lsb, lr});
    write_reg(`REG_STREAM_SEGMENT_THRESHOLD, 0, thr[7:0]);
    write_reg(`REG_STREAM_SEGMENT_THRESHOLD, 1, thr[15:8]);
    write_reg(`REG_STREAM_SEGMENT_THRESHOLD, 2, {7'b0, thr[16]});
    write_reg(`REG_CAPTURE_ARM, 0, 8'h01);
    read_state(`REG_FIFO_STATE, 0, st);
    check_state("state after arm", st, ARMED);
    repeat (lcg_next() % 6) @(posedge clk_usb); // trigger delay
    @(posedge clk_usb);
    trigger <= 1'b1;
    @(posedge clk_usb);
    trigger <= 1'b0;
    for (int i = 0; i < n; i++) begin
      gap = lcg_next() % 4;
      repeat (gap) begin
        @(posedge clk_usb);
        adc_valid <= 1'b0;
      end
      s = lcg_next() >> 16;
      @(posedge clk_usb);
      adc_valid  <= 1'b1;
      adc_sample <= s;
      w = '0;
      if (!lr) begin
        w.full.sample = s;
        push_word(w);
      end else if (!half) begin
        pend = low_res_byte(s, lsb);
        half = 1'b1;
      end else begin
        w.pair.lo = pend;
        w.pair.hi = low_res_byte(s, lsb);
        push_word(w);
        half = 1'b0;
      end
    end
    @(posedge clk_usb);
    adc_valid <= 1'b0;
    if (half) begin
      w = '0;
      w.pair.lo = pend; // odd count, zero high byte
      push_word(w);
    end
    wait_capture_done();
    read_reg(`REG_CAPTURE_DONE, 0, b);
    check_byte("capture_done reg", b, 8'h01);
    read_state(`REG_FIFO_STATE, 0, st);
    check_state("state after capture", st, DONE);
    read_err(`REG_FIFO_STAT, e);
    check_err("fifo_stat after capture", e, make_err(exp_q.size() == 0, exp_ovf, 1'b0));
  endtask

  task automatic readback_words();
    sample_word_u w;
    sample_word_u exp;
    fifo_err_t    e;
    while (exp_q.size() > 0) begin
      read_word(w);
      exp = exp_q.pop_front();
      check_word("fifo word", w, exp);
    end
    read_err(`REG_FIFO_STAT, e);
    check_err("fifo_stat after readback", e, make_err(1'b1, exp_ovf, 1'b0));
  endtask

  initial begin
    int unsigned    mode;
    int unsigned    n;
    logic [31:0]    r;
    logic           fast;
    logic [7:0]     b;
    fifo_err_t      e;
    capture_state_e st;
    sample_word_u   w;
    reset      = 1'b1;
    bus        = '0;
    adc_sample = '0;
    adc_valid  = 1'b0;
    trigger    = 1'b0;
    exp_ovf    = 1'b0;
    repeat (3) @(posedge clk_usb);
    reset <= 1'b0;

    read_state(`REG_FIFO_STATE, 0, st);
    check_state("state after reset", st, IDLE);
    read_reg(`REG_STREAM_SEGMENT_THRESHOLD, 0, b);
    check_byte("threshold byte 0", b, 8'h00);
    read_reg(`REG_STREAM_SEGMENT_THRESHOLD, 1, b);
    check_byte("threshold byte 1", b, 8'h00);
    read_reg(`REG_STREAM_SEGMENT_THRESHOLD, 2, b);
    check_byte("threshold byte 2", b, 8'h01); // 65536
    read_err(`REG_FIFO_STAT, e);
    check_err("fifo_stat after reset", e, make_err(1'b1, 1'b0, 1'b0));
    read_reg(`REG_FAST_FIFO_READ_MODE, 0, b);
    check_byte("fast mode after reset", b, 8'h00);

    // first runs cover full, low-res and low-res lsb, then random modes
    for (int i = 0; i < 6; i++) begin
      r    = lcg_next();
      mode = (i < 3) ? i : r % 3;
      fast = (i == 3) ? 1'b1 : r[8];
      // odd length on the lsb run leaves a half word
      n    = (i == 2) ? 5 + 2 * (lcg_next() % 10) : 4 + lcg_next() % 21;
      run_capture(mode != 0, mode == 2, n);
      if (fast) begin
        write_reg(`REG_FAST_FIFO_READ_MODE, 0, 8'h01);
        read_reg(`REG_FAST_FIFO_READ_MODE, 0, b);
        check_byte("fast mode on", b, 8'h01);
      end
      readback_words();
      if (fast) begin
        write_reg(`REG_ADC_LOW_RES, 0, 8'h00); // ends fast mode
        read_reg(`REG_FAST_FIFO_READ_MODE, 0, b);
        check_byte("fast mode after other write", b, 8'h00);
      end
    end

    // pops from the drained FIFO
    repeat (3) read_word(w);
    read_reg(`REG_FIFO_UNDERFLOW_COUNT, 0, b);
    check_byte("underflow_count", b, 8'd3);
    read_err(`REG_FIFO_STAT, e);
    check_err("fifo_stat after underflow", e, make_err(1'b1, 1'b0, 1'b1));
    read_err(`REG_FIFO_FIRST_ERROR, e);
    check_err("first error", e, make_err(1'b1, 1'b0, 1'b1));
    read_state(`REG_FIFO_FIRST_ERROR, 2, st);
    check_state("first error state", st, DONE);

    write_reg(`REG_FIFO_STAT, 0, 8'h01);
    read_err(`REG_FIFO_STAT, e);
    check_err("fifo_stat during clear", e, make_err(1'b1, 1'b0, 1'b0));
    read_reg(`REG_FIFO_UNDERFLOW_COUNT, 0, b);
    check_byte("underflow_count during clear", b, 8'd0);
    write_reg(`REG_FIFO_STAT, 0, 8'h00);
    read_err(`REG_FIFO_FIRST_ERROR, e);
    check_err("first error after clear", e, make_err(1'b0, 1'b0, 1'b0));

    // masked underflow still counts
    write_reg(`REG_FIFO_NO_UNDERFLOW_ERROR, 0, 8'h01);
    repeat (2) read_word(w);
    read_reg(`REG_FIFO_UNDERFLOW_COUNT, 0, b);
    check_byte("masked underflow_count", b, 8'd2);
    read_err(`REG_FIFO_STAT, e);
    check_err("fifo_stat masked underflow", e, make_err(1'b1, 1'b0, 1'b0));
    write_reg(`REG_FIFO_NO_UNDERFLOW_ERROR, 0, 8'h00);
    write_reg(`REG_FIFO_STAT, 0, 8'h01);
    write_reg(`REG_FIFO_STAT, 0, 8'h00);

    // longer than the FIFO, so the tail is dropped
    n = `ADCFIFO_DEPTH + 1 + lcg_next() % 8;
    run_capture(1'b0, 1'b0, n);
    read_err(`REG_FIFO_FIRST_ERROR, e);
    check_err("first error overflow", e, make_err(1'b0, 1'b1, 1'b0));
    read_state(`REG_FIFO_FIRST_ERROR, 2, st);
    check_state("first error state overflow", st, CAPTURE);
    readback_words();

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// File: all.f
+incdir+src
src/adcfifo_pkg.sv
src/reg_adcfifo.sv
src/adcfifo_capture_fsm.sv
src/adcfifo_sample_counter.sv
src/adcfifo_sample_fifo.sv
src/adcfifo_top.sv
testbench/tb_adcfifo.sv
